/* Bender.yml */
package:
  name: pet_bus

sources:
  - source/pet_bus_pkg.sv
  - source/bus_timing.sv
  - source/spi_port.sv
  - source/cpu_port.sv
  - source/bus_arbiter.sv
  - source/pet_bus_top.sv
  - target: simulation
    files:
      - verification/pet_bus_assertions.sv
      - verification/pet_bus_checker.sv
      - verification/pet_bus_tb.sv

/* pet_bus_top.f */
source/pet_bus_pkg.sv
source/bus_timing.sv
source/spi_port.sv
source/cpu_port.sv
source/bus_arbiter.sv
source/pet_bus_top.sv
verification/pet_bus_assertions.sv
verification/pet_bus_checker.sv
verification/pet_bus_tb.sv

/* source/bus_arbiter.sv */
/*
 * Bus arbiter with shared RAM
 * Picks the owner of the current slot and performs its access on the
 * on-chip RAM at the edge that ends the strobe phase. The old content
 * is returned with a one-clock ack in the following clock.
 */
module bus_arbiter #(
    parameter int ADDR_W = 10
) (
    input  logic                   clk16_i,
    input  logic                   rst_n_i,
    input  pet_bus_pkg::slot_t     slot_i,
    input  pet_bus_pkg::bus_req_t  spi_req_i,
    input  pet_bus_pkg::bus_req_t  cpu_req_i,
    output pet_bus_pkg::bus_resp_t spi_resp_o,
    output pet_bus_pkg::bus_resp_t cpu_resp_o
);

    localparam int DEPTH = 2 ** ADDR_W;

    // shared RAM, 8 bits wide
    logic [7:0] mem [DEPTH];

    logic                  spi_own;
    logic                  cpu_own;
    logic                  spi_go;
    logic                  cpu_go;
    pet_bus_pkg::bus_req_t sel_req;
    logic [ADDR_W-1:0]     ram_addr;
    logic [7:0]            rd_q;
    logic                  spi_ack_q;
    logic                  cpu_ack_q;

    // owner of the strobe phase
    assign spi_own = slot_i.strobe & (slot_i.slot == pet_bus_pkg::SPI_SLOT);
    assign cpu_own = slot_i.strobe & (slot_i.slot == pet_bus_pkg::CPU_SLOT);

    // access only with a pending request
    assign spi_go = spi_own & spi_req_i.valid;
    assign cpu_go = cpu_own & cpu_req_i.valid;

    // slots are exclusive, so one mux is enough
    assign sel_req  = spi_own ? spi_req_i : cpu_req_i;

    // address taken modulo the RAM size
    assign ram_addr = sel_req.addr[ADDR_W-1:0];

    // read old content, then write if requested
    always_ff @(posedge clk16_i) begin
        if (spi_go || cpu_go) begin
            rd_q <= mem[ram_addr];
            if (sel_req.we) begin
                mem[ram_addr] <= sel_req.wdata;
            end
        end
    end

    // ack for the clock after the access edge
    always_ff @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            spi_ack_q <= 1'b0;
            cpu_ack_q <= 1'b0;
        end else begin
            spi_ack_q <= spi_go;
            cpu_ack_q <= cpu_go;
        end
    end

    // shared read register, qualified by each owner's ack
    always_comb begin
        spi_resp_o.ack   = spi_ack_q;
        spi_resp_o.rdata = rd_q;
        cpu_resp_o.ack   = cpu_ack_q;
        cpu_resp_o.rdata = rd_q;
    end

endmodule

/* source/bus_timing.sv */
/*
 * Bus timing
 * Frame counter for the 16-clock bus frame. Decodes the slot number and
 * the setup/strobe phases, and produces the CPU bus-enable window and
 * the one-clock CPU clock pulse at the end of the CPU slot.
 */
module bus_timing (
    input  logic                clk16_i,
    input  logic                rst_n_i,
    output pet_bus_pkg::slot_t  slot_o,
    output logic                cpu_be_o,
    output logic                cpu_clk_o
);

    localparam int CNT_W = $clog2(pet_bus_pkg::FRAME_CLKS);

    // be window covers the last two slots of the frame
    localparam logic [CNT_W-1:0] BE_FIRST  = CNT_W'(pet_bus_pkg::FRAME_CLKS - 4);
    localparam logic [CNT_W-1:0] CLK_COUNT = CNT_W'(pet_bus_pkg::FRAME_CLKS - 1);

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;
    logic             cpu_be_q;
    logic             cpu_clk_q;

    // natural wrap at 16
    assign cnt_d = cnt_q + 1'b1;

    always_ff @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    // registered from the next count so both are clean one-clock levels
    always_ff @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cpu_be_q  <= 1'b0;
            cpu_clk_q <= 1'b0;
        end else begin
            cpu_be_q  <= (cnt_d >= BE_FIRST);
            cpu_clk_q <= (cnt_d == CLK_COUNT);
        end
    end

    // slot = count/2, even counts setup, odd counts strobe
    always_comb begin
        slot_o.slot   = cnt_q[CNT_W-1:1];
        slot_o.setup  = ~cnt_q[0];
        slot_o.strobe = cnt_q[0];
    end

    assign cpu_be_o  = cpu_be_q;
    assign cpu_clk_o = cpu_clk_q;

endmodule

/* source/cpu_port.sv */
/*
 * CPU port
 * Samples the CPU request just before the CPU slot so the address is
 * stable through the access, and holds the last returned byte as the
 * value on the CPU data bus between accesses.
 */
module cpu_port (
    input  logic                   clk16_i,
    input  logic                   rst_n_i,
    input  pet_bus_pkg::slot_t     slot_i,
    input  pet_bus_pkg::bus_req_t  cpu_req_i,
    input  pet_bus_pkg::bus_resp_t resp_i,
    output logic [7:0]             cpu_rdata_o,
    output pet_bus_pkg::bus_req_t  req_o
);

    // slot just before the be window
    localparam logic [2:0] CAPTURE_SLOT = pet_bus_pkg::CPU_SLOT - 3'd2;

    logic                  capture;
    logic                  valid_q;
    logic [7:0]            rdata_q;
    pet_bus_pkg::bus_req_t req_q;

    // edge that ends count 11, i.e. start of slot 6
    assign capture = slot_i.strobe & (slot_i.slot == CAPTURE_SLOT);

    always_ff @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (capture) begin
            valid_q <= cpu_req_i.valid;
        end
    end

    // address and data, held through slots 6 and 7
    always_ff @(posedge clk16_i) begin
        if (capture) begin
            req_q <= cpu_req_i;
        end
    end

    // data bus value, taken on the ack clock for reads and writes
    always_ff @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_q <= '0;
        end else if (resp_i.ack) begin
            rdata_q <= resp_i.rdata;
        end
    end

    always_comb begin
        req_o       = req_q;
        req_o.valid = valid_q;
    end

    assign cpu_rdata_o = rdata_q;

endmodule

/* source/pet_bus_pkg.sv */
/*
 * PET shared bus definitions
 * Request, response and slot types used by the timing block, the
 * SPI and CPU ports and the bus arbiter, plus the frame constants.
 */
package pet_bus_pkg;

    // full 16-bit address as seen by SPI host and CPU
    localparam int BUS_ADDR_W = 16;

    // one bus frame, 8 slots of setup + strobe
    localparam int FRAME_CLKS = 16;

    // slot ownership
    localparam logic [2:0] SPI_SLOT = 3'd0;
    localparam logic [2:0] CPU_SLOT = 3'd7;

    // one access request
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [BUS_ADDR_W-1:0] addr;
        logic [7:0]            wdata;
    } bus_req_t;

    // completion of one access
    // ack is a single clock pulse, rdata is the old RAM content
    typedef struct packed {
        logic       ack;
        logic [7:0] rdata;
    } bus_resp_t;

    // current position within the frame
    typedef struct packed {
        logic [2:0] slot;
        logic       setup;
        logic       strobe;
    } slot_t;

endpackage

/* source/pet_bus_top.sv */
/*
 * PET shared bus core
 * Frame timing, SPI host port, CPU port and the arbiter in front of
 * the shared on-chip RAM.
 */
module pet_bus_top #(
    parameter int ADDR_W = 10
) (
    input  logic                  clk16_i,
    input  logic                  rst_n_i,
    input  logic                  spi_valid_i,
    input  pet_bus_pkg::bus_req_t spi_req_i,
    input  pet_bus_pkg::bus_req_t cpu_req_i,
    output logic                  spi_ready_o,
    output logic [7:0]            spi_rdata_o,
    output logic [7:0]            cpu_rdata_o,
    output logic                  cpu_be_o,
    output logic                  cpu_clk_o
);

    pet_bus_pkg::slot_t     slot;
    pet_bus_pkg::bus_req_t  spi_bus_req;
    pet_bus_pkg::bus_req_t  cpu_bus_req;
    pet_bus_pkg::bus_resp_t spi_bus_resp;
    pet_bus_pkg::bus_resp_t cpu_bus_resp;

    // frame position and cpu clocking
    bus_timing u_timing (
        .clk16_i   (clk16_i),
        .rst_n_i   (rst_n_i),
        .slot_o    (slot),
        .cpu_be_o  (cpu_be_o),
        .cpu_clk_o (cpu_clk_o)
    );

    // spi host side
    spi_port u_spi (
        .clk16_i     (clk16_i),
        .rst_n_i     (rst_n_i),
        .spi_valid_i (spi_valid_i),
        .spi_req_i   (spi_req_i),
        .resp_i      (spi_bus_resp),
        .spi_ready_o (spi_ready_o),
        .spi_rdata_o (spi_rdata_o),
        .req_o       (spi_bus_req)
    );

    // cpu side
    cpu_port u_cpu (
        .clk16_i     (clk16_i),
        .rst_n_i     (rst_n_i),
        .slot_i      (slot),
        .cpu_req_i   (cpu_req_i),
        .resp_i      (cpu_bus_resp),
        .cpu_rdata_o (cpu_rdata_o),
        .req_o       (cpu_bus_req)
    );

    // shared ram
    bus_arbiter #(
        .ADDR_W (ADDR_W)
    ) u_arbiter (
        .clk16_i    (clk16_i),
        .rst_n_i    (rst_n_i),
        .slot_i     (slot),
        .spi_req_i  (spi_bus_req),
        .cpu_req_i  (cpu_bus_req),
        .spi_resp_o (spi_bus_resp),
        .cpu_resp_o (cpu_bus_resp)
    );

endmodule

/* source/spi_port.sv */
/*
 * SPI host port
 * One-entry request holder between the SPI host and the shared bus.
 * Takes a request under valid/ready, keeps it until the arbiter acks
 * it in the SPI slot, then returns the read data and reopens.
 */
module spi_port (
    input  logic                   clk16_i,
    input  logic                   rst_n_i,
    input  logic                   spi_valid_i,
    input  pet_bus_pkg::bus_req_t  spi_req_i,
    input  pet_bus_pkg::bus_resp_t resp_i,
    output logic                   spi_ready_o,
    output logic [7:0]             spi_rdata_o,
    output pet_bus_pkg::bus_req_t  req_o
);

    logic                  ready_q;
    logic                  pend_q;
    logic [7:0]            rdata_q;
    pet_bus_pkg::bus_req_t hold_q;
    logic                  accept;

    // handshake completes on this edge
    assign accept = spi_valid_i & ready_q;

    // ready drops on acceptance, comes back with the ack
    // accept and ack never overlap since ready is low while pending
    always_ff @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ready_q <= 1'b1;
            pend_q  <= 1'b0;
            rdata_q <= '0;
        end else if (accept) begin
            ready_q <= 1'b0;
            pend_q  <= 1'b1;
        end else if (resp_i.ack) begin
            ready_q <= 1'b1;
            pend_q  <= 1'b0;
            rdata_q <= resp_i.rdata;
        end
    end

    // request payload, host valid bit is not used
    always_ff @(posedge clk16_i) begin
        if (accept) begin
            hold_q <= spi_req_i;
        end
    end

    // valid comes from the pending flag
    always_comb begin
        req_o       = hold_q;
        req_o.valid = pend_q;
    end

    assign spi_ready_o = ready_q;
    assign spi_rdata_o = rdata_q;

endmodule

/* verification/pet_bus_assertions.sv */
/*
 * Bus timing assertions
 * Bound into bus_timing. Checks the CPU clock pulse width, the pulse
 * inside the bus-enable window and the slot sequence.
 */
module pet_bus_assertions (
    input logic               clk16_i,
    input logic               rst_n_i,
    input pet_bus_pkg::slot_t slot_i,
    input logic               cpu_be_i,
    input logic               cpu_clk_i
);

    // number of failed assertions
    int fail_cnt = 0;

    // cpu clock is a single-clock pulse
    clk_one_wide: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        cpu_clk_i |=> !cpu_clk_i)
        else begin
            $error("cpu_clk_o stayed high for more than one clock");
            fail_cnt++;
        end

    clk_in_be: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        cpu_clk_i |-> cpu_be_i)
        else begin
            $error("cpu_clk_o high outside the bus-enable window");
            fail_cnt++;
        end

    // setup then strobe in one slot, then setup of the next slot
    setup_to_strobe: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        slot_i.setup |=> slot_i.strobe && (slot_i.slot == $past(slot_i.slot)))
        else begin
            $error("strobe phase did not follow setup in the same slot");
            fail_cnt++;
        end

    strobe_to_next: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        slot_i.strobe |=> slot_i.setup && (slot_i.slot == $past(slot_i.slot) + 3'd1))
        else begin
            $error("slot number did not advance by one");
            fail_cnt++;
        end

endmodule

bind bus_timing pet_bus_assertions u_timing_assert (
    .clk16_i   (clk16_i),
    .rst_n_i   (rst_n_i),
    .slot_i    (slot_o),
    .cpu_be_i  (cpu_be_o),
    .cpu_clk_i (cpu_clk_o)
);

/* verification/pet_bus_checker.sv */
/*
 * Bus checker
 * Tracks the frame position from reset release, applies SPI and CPU
 * accesses to a model RAM at their access edges and compares the DUT
 * outputs on every falling edge.
 */
module pet_bus_checker #(
    parameter int ADDR_W = 10
) (
    input  logic                  clk16_i,
    input  logic                  rst_n_i,
    input  logic                  spi_valid_i,
    input  pet_bus_pkg::bus_req_t spi_req_i,
    input  pet_bus_pkg::bus_req_t cpu_req_i,
    input  logic                  spi_ready_i,
    input  logic [7:0]            spi_rdata_i,
    input  logic [7:0]            cpu_rdata_i,
    input  logic                  cpu_be_i,
    input  logic                  cpu_clk_i,
    output int                    err_cnt_o,
    output int                    chk_cnt_o
);

    logic [7:0]            mem [2**ADDR_W];
    logic [3:0]            cnt;
    logic                  exp_ready;
    logic                  ready_old;
    logic                  ready_seen;
    logic [7:0]            exp_spi;
    logic [7:0]            exp_cpu;
    logic [7:0]            spi_old;
    logic [7:0]            cpu_old;
    logic                  spi_pend;
    logic                  spi_ack;
    logic                  cpu_ack;
    int                    edge_cnt;
    int                    acc_edge;
    pet_bus_pkg::bus_req_t spi_hold;
    pet_bus_pkg::bus_req_t cpu_hold;

    // read old byte, then write, address modulo the RAM size
    function automatic logic [7:0] access(input pet_bus_pkg::bus_req_t r);
        logic [7:0] old;
        old = mem[r.addr[ADDR_W-1:0]];
        if (r.we) begin
            mem[r.addr[ADDR_W-1:0]] = r.wdata;
        end
        return old;
    endfunction

    task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
        chk_cnt_o++;
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            err_cnt_o++;
        end
    endtask

    initial begin
        err_cnt_o  = 0;
        chk_cnt_o  = 0;
        ready_seen = 1'b1;
    end

    // model steps at each rising edge, cnt is the count that edge ends
    always @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt       = '0;
            exp_ready = 1'b1;
            exp_spi   = '0;
            exp_cpu   = '0;
            spi_pend  = 1'b0;
            spi_ack   = 1'b0;
            cpu_ack   = 1'b0;
            cpu_hold  = '0;
            edge_cnt  = 0;
            acc_edge  = 0;
        end else begin
            ready_old = exp_ready;
            edge_cnt++;
            // results of the previous access edge
            if (spi_ack) begin
                exp_ready = 1'b1;
                exp_spi   = spi_old;
                spi_ack   = 1'b0;
            end
            if (cpu_ack) begin
                exp_cpu = cpu_old;
                cpu_ack = 1'b0;
            end
            // spi owns the edge ending count 1, cpu the one ending count 15
            if (cnt == 4'd1 && spi_pend) begin
                spi_old  = access(spi_hold);
                spi_ack  = 1'b1;
                spi_pend = 1'b0;
            end
            if (cnt == 4'd15 && cpu_hold.valid) begin
                cpu_old = access(cpu_hold);
                cpu_ack = 1'b1;
            end
            if (cnt == 4'd11) begin
                cpu_hold = cpu_req_i;
            end
            if (ready_old && spi_valid_i) begin
                spi_hold  = spi_req_i;
                spi_pend  = 1'b1;
                exp_ready = 1'b0;
                acc_edge  = edge_cnt;
            end
            cnt = cnt + 4'd1;
        end
    end

    always @(negedge clk16_i) begin
        check("spi_ready_o", spi_ready_i, exp_ready);
        check("spi_rdata_o", spi_rdata_i, exp_spi);
        check("cpu_rdata_o", cpu_rdata_i, exp_cpu);
        check("cpu_be_o", cpu_be_i, cnt >= 4'd12);
        check("cpu_clk_o", cpu_clk_i, cnt == 4'd15);
        // ready rising ends one spi transfer
        if (spi_ready_i && !ready_seen) begin
            chk_cnt_o++;
            if (edge_cnt - acc_edge < 2 || edge_cnt - acc_edge > 17) begin
                $display("Error at %0t: spi latency is %0d clocks, expected 2 to 17",
                         $time, edge_cnt - acc_edge);
                err_cnt_o++;
            end
        end
        ready_seen = spi_ready_i;
    end

endmodule

/* verification/pet_bus_tb.sv */
/*
 * PET shared bus testbench
 * Random SPI and CPU traffic from an LFSR into the bus core, the
 * checker compares every clock against its RAM model.
 */
module pet_bus_tb;

    localparam int ADDR_W = 10;

    // starts low without an edge at time zero
    logic                  clk16_i = 1'b0;
    logic                  rst_n_i;
    logic                  spi_valid_i;
    pet_bus_pkg::bus_req_t spi_req_i;
    pet_bus_pkg::bus_req_t cpu_req_i;
    logic                  spi_ready_o;
    logic [7:0]            spi_rdata_o;
    logic [7:0]            cpu_rdata_o;
    logic                  cpu_be_o;
    logic                  cpu_clk_o;
    int                    err_cnt;
    int                    chk_cnt;
    int                    err_mark;
    logic [31:0]           lfsr_q;
    logic                  hung;

    pet_bus_top #(.ADDR_W(ADDR_W)) DUT (
        .clk16_i     (clk16_i),
        .rst_n_i     (rst_n_i),
        .spi_valid_i (spi_valid_i),
        .spi_req_i   (spi_req_i),
        .cpu_req_i   (cpu_req_i),
        .spi_ready_o (spi_ready_o),
        .spi_rdata_o (spi_rdata_o),
        .cpu_rdata_o (cpu_rdata_o),
        .cpu_be_o    (cpu_be_o),
        .cpu_clk_o   (cpu_clk_o)
    );

    pet_bus_checker #(.ADDR_W(ADDR_W)) u_check (
        .clk16_i     (clk16_i),
        .rst_n_i     (rst_n_i),
        .spi_valid_i (spi_valid_i),
        .spi_req_i   (spi_req_i),
        .cpu_req_i   (cpu_req_i),
        .spi_ready_i (spi_ready_o),
        .spi_rdata_i (spi_rdata_o),
        .cpu_rdata_i (cpu_rdata_o),
        .cpu_be_i    (cpu_be_o),
        .cpu_clk_i   (cpu_clk_o),
        .err_cnt_o   (err_cnt),
        .chk_cnt_o   (chk_cnt)
    );

    always #20 clk16_i = ~clk16_i;

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // 16-byte window at 0x2a0, upper bits beyond the RAM random
    function automatic pet_bus_pkg::bus_req_t rand_req(input int fill);
        pet_bus_pkg::bus_req_t r;
        logic [31:0]           b;
        b       = take_bits(19);
        r.valid = 1'b1;
        r.we    = b[18] | (fill >= 0);
        r.addr  = {b[17:12], 6'h2a, b[11:8]};
        r.wdata = b[7:0];
        if (fill >= 0) begin
            r.addr[3:0] = fill[3:0];
        end
        return r;
    endfunction

    task automatic end_test(input string name);
        $display("test %-20s done, %0d errors", name, err_cnt - err_mark);
        err_mark = err_cnt;
    endtask

    task automatic wait_cpu_pulse();
        int n;
        n = 0;
        @(negedge clk16_i);
        while (!cpu_clk_o && n < 20) begin
            @(negedge clk16_i);
            n++;
        end
        if (!cpu_clk_o) begin
            $display("Timeout: no cpu_clk_o pulse within 20 clocks");
            hung = 1'b1;
        end
    endtask

    // new cpu request in the clock after each pulse
    task automatic cpu_frames(input int frames);
        for (int i = 0; i < frames; i++) begin
            wait_cpu_pulse();
            @(negedge clk16_i);
            cpu_req_i = rand_req(-1);
        end
    endtask

    // spi host, valid held until accepted, gap sets how often it rests
    task automatic spi_run(input int count, input int fill, input int gap);
        int   sent;
        int   stall;
        logic go;
        sent        = 0;
        stall       = 0;
        spi_valid_i = 1'b1;
        spi_req_i   = rand_req(fill);
        while (sent < count && !hung) begin
            // handshake completes at the coming edge when ready is high now
            go = spi_valid_i & spi_ready_o;
            @(negedge clk16_i);
            if (go || !spi_valid_i) begin
                sent        = sent + int'(go);
                stall       = 0;
                spi_req_i   = rand_req(fill < 0 ? -1 : fill + sent);
                spi_valid_i = (take_bits(2) >= gap);
            end else begin
                stall++;
                if (stall >= 40) begin
                    $display("Timeout: spi_ready_o stayed low for 40 clocks");
                    hung = 1'b1;
                end
            end
        end
        spi_valid_i = 1'b0;
    endtask

    initial begin
        rst_n_i     = 1'b0;
        spi_valid_i = 1'b0;
        spi_req_i   = '0;
        cpu_req_i   = '0;
        lfsr_q      = 32'h5d45cddf;
        hung        = 1'b0;
        err_mark    = 0;
        repeat (5) @(negedge clk16_i);
        rst_n_i = 1'b1;
        end_test("reset values");
        for (int i = 0; i < 20; i++) begin
            wait_cpu_pulse();
        end
        end_test("frame timing");
        // fill the window first, then random reads and writes
        spi_run(16, 0, 0);
        spi_run(40, -1, 2);
        end_test("spi path");
        cpu_frames(24);
        end_test("cpu path");
        fork
            cpu_frames(16);
            spi_run(48, -1, 1);
        join
        end_test("shared ram ordering");
        spi_run(48, -1, 0);
        wait_cpu_pulse();
        wait_cpu_pulse();
        end_test("back-pressure");
        $display("tests run: 6, checks: %0d, errors: %0d, assertion failures: %0d",
                 chk_cnt, err_cnt, DUT.u_timing.u_timing_assert.fail_cnt);
        if (hung || err_cnt != 0 || DUT.u_timing.u_timing_assert.fail_cnt != 0) begin
            $display("Simulation finished: FAIL");
        end else begin
            $display("Simulation finished: PASS");
        end
        $finish;
    end

endmodule
